//--- periph_macros.svh
// Peripheral hub widths, slot counts and address map
// Shared by the package and every hub module

`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// Core request address width, bit 10 selects simple space
`define PERIPH_ADDR_W 11

// Byte peripheral copies and output pins
`define PERIPH_NUM_SIMPLE 4
`define PERIPH_NUM_PINS 8

// GPIO lives in user slot 1 (0x040 to 0x07F)
`define PERIPH_GPIO_SLOT 1
`define PERIPH_GPIO_OUT_OFS 6'h00
`define PERIPH_GPIO_IN_OFS 6'h04
// First of eight word-spaced function select registers
`define PERIPH_GPIO_SEL_OFS 6'h20

// Function select width: space bit plus 4-bit slot
`define PERIPH_SEL_W 5

`endif

//--- periph_pkg.sv
// Types shared across the peripheral hub
// Request size codes, read return state and pin function select

`include "periph_macros.svh"

package periph_pkg;

    // Encoding of the core's read and write request codes
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_t;

    typedef enum logic {
        RD_IDLE,
        RD_HOLD
    } read_state_t;

    // Top bit picks byte peripheral space, low bits the slot
    typedef struct packed {
        logic                        simple;
        logic [`PERIPH_SEL_W-2:0]    slot;
    } func_sel_t;

endpackage

//--- addr_decoder.sv
// Address decoder for the peripheral hub
// Splits the request address into GPIO and byte peripheral selects and write strobes

`timescale 1ns/1ps
`include "periph_macros.svh"

module addr_decoder import periph_pkg::*; (
    input  logic [`PERIPH_ADDR_W-1:0]     i_addr,
    input  access_t                       i_data_write_n,
    output logic                          o_gpio_sel,
    output logic                          o_gpio_wr,
    output logic [`PERIPH_NUM_SIMPLE-1:0] o_simple_sel,
    output logic [`PERIPH_NUM_SIMPLE-1:0] o_simple_wr
);

    logic simple_space;
    logic wr_req;

    assign simple_space = i_addr[`PERIPH_ADDR_W-1];
    assign wr_req       = (i_data_write_n != ACC_NONE);

    always_comb begin
        // User space, only the GPIO slot is mapped
        o_gpio_sel = !simple_space && (i_addr[9:6] == 4'(`PERIPH_GPIO_SLOT));

        // Simple space, slots past the last copy stay unselected
        for (int s = 0; s < `PERIPH_NUM_SIMPLE; s++) begin
            o_simple_sel[s] = simple_space && (i_addr[7:4] == 4'(s));
        end
    end

    assign o_gpio_wr   = o_gpio_sel && wr_req;
    assign o_simple_wr = o_simple_sel & {`PERIPH_NUM_SIMPLE{wr_req}};

endmodule

//--- byte_periph.sv
// Simple byte peripheral with four writable registers
// Register 0 drives the peripheral's pin outputs

`timescale 1ns/1ps
`include "periph_macros.svh"

module byte_periph (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_wr,
    input  logic [3:0]                  i_reg_addr,
    input  logic [7:0]                  i_wdata,
    output logic [7:0]                  o_rdata,
    output logic [`PERIPH_NUM_PINS-1:0] o_pins
);

    logic [3:0][7:0] regs_q;
    logic            reg_hit;

    // Only register addresses 0 to 3 exist
    assign reg_hit = (i_reg_addr[3:2] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs_q <= '0;
        end else if (i_wr && reg_hit) begin
            regs_q[i_reg_addr[1:0]] <= i_wdata;
        end
    end

    assign o_rdata = reg_hit ? regs_q[i_reg_addr[1:0]] : 8'h00;
    assign o_pins  = regs_q[0];

endmodule

//--- gpio_ctrl.sv
// GPIO block: output register, input readback and per-pin function selects
// Read data is combinational from the slot offset and zero-extended

`timescale 1ns/1ps
`include "periph_macros.svh"

module gpio_ctrl import periph_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               i_wr,
    input  logic [5:0]                         i_offset,
    input  logic [31:0]                        i_wdata,
    input  logic [`PERIPH_NUM_PINS-1:0]        i_ui_in,
    output logic [31:0]                        o_rdata,
    output logic [`PERIPH_NUM_PINS-1:0]        o_gpio_out,
    output func_sel_t [`PERIPH_NUM_PINS-1:0]   o_func_sel
);

    // Every pin starts on the GPIO output register
    localparam func_sel_t SEL_RESET = '{simple: 1'b0, slot: `PERIPH_GPIO_SLOT};

    logic [`PERIPH_NUM_PINS-1:0]        gpio_out_q;
    func_sel_t [`PERIPH_NUM_PINS-1:0]   sel_q;

    logic out_hit;
    logic in_hit;
    logic sel_hit;

    assign out_hit = (i_offset == `PERIPH_GPIO_OUT_OFS);
    assign in_hit  = (i_offset == `PERIPH_GPIO_IN_OFS);
    // Word-aligned offsets 0x20 to 0x3C, bits 4:2 pick the pin
    assign sel_hit = ((i_offset & 6'h23) == `PERIPH_GPIO_SEL_OFS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
        end else if (i_wr && out_hit) begin
            gpio_out_q <= i_wdata[`PERIPH_NUM_PINS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q <= {`PERIPH_NUM_PINS{SEL_RESET}};
        end else if (i_wr && sel_hit) begin
            sel_q[i_offset[4:2]] <= func_sel_t'(i_wdata[`PERIPH_SEL_W-1:0]);
        end
    end

    always_comb begin
        if (out_hit) begin
            o_rdata = 32'(gpio_out_q);
        end else if (in_hit) begin
            o_rdata = 32'(i_ui_in);
        end else if (sel_hit) begin
            o_rdata = 32'(sel_q[i_offset[4:2]]);
        end else begin
            o_rdata = 32'h0;
        end
    end

    assign o_gpio_out = gpio_out_q;
    assign o_func_sel = sel_q;

endmodule

//--- pin_mux.sv
// Output pin routing, each pin picks GPIO or one byte peripheral
// Unknown user slots and missing byte slots drive zero

`timescale 1ns/1ps
`include "periph_macros.svh"

module pin_mux import periph_pkg::*; (
    input  func_sel_t [`PERIPH_NUM_PINS-1:0]                        i_func_sel,
    input  logic [`PERIPH_NUM_PINS-1:0]                             i_gpio_out,
    input  logic [`PERIPH_NUM_SIMPLE-1:0][`PERIPH_NUM_PINS-1:0]     i_simple_pins,
    output logic [`PERIPH_NUM_PINS-1:0]                             o_uo_out
);

    always_comb begin
        for (int k = 0; k < `PERIPH_NUM_PINS; k++) begin
            o_uo_out[k] = 1'b0;
            if (i_func_sel[k].simple) begin
                for (int s = 0; s < `PERIPH_NUM_SIMPLE; s++) begin
                    if (i_func_sel[k].slot == 4'(s)) begin
                        o_uo_out[k] = i_simple_pins[s][k];
                    end
                end
            end else if (i_func_sel[k].slot == 4'(`PERIPH_GPIO_SLOT)) begin
                o_uo_out[k] = i_gpio_out[k];
            end
        end
    end

endmodule

//--- read_return.sv
// Registered read return port for the core
// Captures the selected read data and holds it until the core completes the read

`timescale 1ns/1ps
`include "periph_macros.svh"

module read_return import periph_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    input  access_t                             i_data_read_n,
    input  access_t                             i_data_write_n,
    input  logic                                i_data_read_complete,
    input  logic                                i_gpio_sel,
    input  logic [`PERIPH_NUM_SIMPLE-1:0]       i_simple_sel,
    input  logic [31:0]                         i_gpio_rdata,
    input  logic [`PERIPH_NUM_SIMPLE-1:0][7:0]  i_simple_rdata,
    output logic [31:0]                         o_data_out,
    output logic                                o_data_ready
);

    read_state_t state_q;
    logic [31:0] data_q;
    logic        ready_q;
    logic [31:0] rdata_mux;
    logic        read_req;
    logic        capture;

    assign read_req = (i_data_read_n != ACC_NONE);
    assign capture  = (state_q == RD_IDLE) && read_req;

    // Selects are one-hot, unmapped addresses fall through to zero
    always_comb begin
        rdata_mux = i_gpio_sel ? i_gpio_rdata : 32'h0;
        for (int s = 0; s < `PERIPH_NUM_SIMPLE; s++) begin
            if (i_simple_sel[s]) begin
                rdata_mux = 32'(i_simple_rdata[s]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= RD_IDLE;
            ready_q <= 1'b0;
        end else begin
            case (state_q)
                RD_IDLE: if (read_req) state_q <= RD_HOLD;
                RD_HOLD: if (i_data_read_complete) state_q <= RD_IDLE;
                default: state_q <= RD_IDLE;
            endcase
            // Ready rises with the capture and drops after completion or request loss
            ready_q <= read_req && (capture || (ready_q && !i_data_read_complete));
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= rdata_mux;
        end
    end

    assign o_data_out = data_q;
    // Writes are acknowledged in the same cycle
    assign o_data_ready = ready_q || (i_data_write_n != ACC_NONE);

endmodule

//--- periph_hub.sv
// Peripheral hub top level
// Decodes core requests to GPIO or byte peripherals and routes their pins

`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_hub import periph_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`PERIPH_NUM_PINS-1:0] i_ui_in,
    input  logic [`PERIPH_ADDR_W-1:0]   i_addr,
    input  logic [31:0]                 i_data_in,
    input  access_t                     i_data_write_n,
    input  access_t                     i_data_read_n,
    input  logic                        i_data_read_complete,
    output logic [`PERIPH_NUM_PINS-1:0] o_uo_out,
    output logic [31:0]                 o_data_out,
    output logic                        o_data_ready
);

    logic                                               gpio_sel;
    logic                                               gpio_wr;
    logic [`PERIPH_NUM_SIMPLE-1:0]                      simple_sel;
    logic [`PERIPH_NUM_SIMPLE-1:0]                      simple_wr;

    logic [31:0]                                        gpio_rdata;
    logic [`PERIPH_NUM_PINS-1:0]                        gpio_out;
    func_sel_t [`PERIPH_NUM_PINS-1:0]                   func_sel;

    logic [`PERIPH_NUM_SIMPLE-1:0][7:0]                 simple_rdata;
    logic [`PERIPH_NUM_SIMPLE-1:0][`PERIPH_NUM_PINS-1:0] simple_pins;

    addr_decoder i_addr_decoder (
        .i_addr         (i_addr),
        .i_data_write_n (i_data_write_n),
        .o_gpio_sel     (gpio_sel),
        .o_gpio_wr      (gpio_wr),
        .o_simple_sel   (simple_sel),
        .o_simple_wr    (simple_wr)
    );

    gpio_ctrl i_gpio_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wr       (gpio_wr),
        .i_offset   (i_addr[5:0]),
        .i_wdata    (i_data_in),
        .i_ui_in    (i_ui_in),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel)
    );

    // Byte peripherals see only the low data byte and register address
    for (genvar s = 0; s < `PERIPH_NUM_SIMPLE; s++) begin : g_simple
        byte_periph i_byte_periph (
            .clk        (clk),
            .rst_n      (rst_n),
            .i_wr       (simple_wr[s]),
            .i_reg_addr (i_addr[3:0]),
            .i_wdata    (i_data_in[7:0]),
            .o_rdata    (simple_rdata[s]),
            .o_pins     (simple_pins[s])
        );
    end

    pin_mux i_pin_mux (
        .i_func_sel    (func_sel),
        .i_gpio_out    (gpio_out),
        .i_simple_pins (simple_pins),
        .o_uo_out      (o_uo_out)
    );

    read_return i_read_return (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_complete (i_data_read_complete),
        .i_gpio_sel           (gpio_sel),
        .i_simple_sel         (simple_sel),
        .i_gpio_rdata         (gpio_rdata),
        .i_simple_rdata       (simple_rdata),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

endmodule

//--- periph_hub_assertions.sv
// Handshake assertions for the peripheral hub core port
// Bound into the hub top level

`timescale 1ns/1ps

module periph_hub_assertions import periph_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input access_t     i_data_write_n,
    input access_t     i_data_read_n,
    input logic        i_data_read_complete,
    input logic [31:0] o_data_out,
    input logic        o_data_ready
);

    logic write_req;
    logic read_req;
    int   fail_count = 0;

    assign write_req = (i_data_write_n != ACC_NONE);
    assign read_req  = (i_data_read_n != ACC_NONE);

    a_write_ack: assert property (@(posedge clk) disable iff (!rst_n)
        write_req |-> o_data_ready)
        else begin
            $error("write request without ready in the same cycle");
            fail_count++;
        end

    // Held data must not move before the core completes
    a_read_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (read_req && !write_req && o_data_ready && !i_data_read_complete)
        |=> $stable(o_data_out))
        else begin
            $error("read data changed before completion");
            fail_count++;
        end

    a_ready_cause: assert property (@(posedge clk) disable iff (!rst_n)
        (o_data_ready && !write_req) |-> $past(read_req))
        else begin
            $error("read ready without a read request in the previous cycle");
            fail_count++;
        end

endmodule

bind periph_hub periph_hub_assertions i_periph_hub_assertions (
    .clk                  (clk),
    .rst_n                (rst_n),
    .i_data_write_n       (i_data_write_n),
    .i_data_read_n        (i_data_read_n),
    .i_data_read_complete (i_data_read_complete),
    .o_data_out           (o_data_out),
    .o_data_ready         (o_data_ready)
);

//--- tb_periph_hub.sv
// Testbench for the peripheral hub
// Directed tests over GPIO, pin routing, byte peripherals and the read port

`timescale 1ns/1ps
`include "periph_macros.svh"

module tb_periph_hub import periph_pkg::*; ();

    // Tests take about 400 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        rst_n;
    logic [7:0]  ui_in;
    logic [10:0] addr;
    logic [31:0] data_in;
    access_t     data_write_n;
    access_t     data_read_n;
    logic        data_read_complete;
    logic [7:0]  uo_out;
    logic [31:0] data_out;
    logic        data_ready;

    // Reference model of the register state
    logic [7:0]  gpio_out_m;
    logic [4:0]  sel_m [`PERIPH_NUM_PINS];
    logic [7:0]  regs_m [`PERIPH_NUM_SIMPLE][4];

    logic [31:0] rng_state = 32'h15e32d6e;
    int          errors = 0;
    int          errors_seen = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          cycle_count = 0;
    int          assert_fails;

    periph_hub i_periph_hub (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .i_addr               (addr),
        .i_data_in            (data_in),
        .i_data_write_n       (data_write_n),
        .i_data_read_n        (data_read_n),
        .i_data_read_complete (data_read_complete),
        .o_uo_out             (uo_out),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [10:0] simple_addr(input int s, input int r);
        return {1'b1, 2'b00, 4'(s), 4'(r)};
    endfunction

    function automatic logic [10:0] sel_addr(input int k);
        return 11'h060 + 11'(4 * k);
    endfunction

    // Byte slot when the space bit is set, else only user slot 1 drives
    function automatic logic [7:0] expected_pins();
        logic [7:0] pins;
        logic [3:0] slot;
        pins = '0;
        for (int k = 0; k < 8; k++) begin
            slot = sel_m[k][3:0];
            if (sel_m[k][4] && slot < `PERIPH_NUM_SIMPLE) begin
                pins[k] = regs_m[slot][0][k];
            end else if (!sel_m[k][4] && slot == `PERIPH_GPIO_SLOT) begin
                pins[k] = gpio_out_m[k];
            end
        end
        return pins;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s: expected %08h, actual %08h", name, exp, got);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_seen) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - errors_seen);
        end
        errors_seen = errors;
    endtask

    // Bus tasks start and end just after a falling edge
    task automatic bus_write(input logic [10:0] a, input logic [31:0] d);
        addr = a;
        data_in = d;
        data_write_n = ACC_WORD;
        @(negedge clk);
        data_write_n = ACC_NONE;
    endtask

    task automatic read_held(input logic [10:0] a, input logic [10:0] alt, input int hold,
                             output logic [31:0] d);
        addr = a;
        data_read_n = ACC_WORD;
        @(negedge clk);
        while (!data_ready) begin
            @(negedge clk);
        end
        d = data_out;
        // Move the address away while the request is still held
        addr = alt;
        repeat (hold) begin
            @(negedge clk);
            check_value("held read data", d, data_out);
            check_value("held read ready", 32'h1, 32'(data_ready));
        end
        data_read_n = ACC_NONE;
        data_read_complete = 1'b1;
        @(negedge clk);
        data_read_complete = 1'b0;
    endtask

    task automatic bus_read(input logic [10:0] a, output logic [31:0] d);
        read_held(a, a, 0, d);
    endtask

    task automatic expect_read(input string name, input logic [10:0] a,
                               input logic [31:0] exp);
        logic [31:0] d;
        bus_read(a, d);
        check_value(name, exp, d);
    endtask

    task automatic test_reset_values();
        check_value("reset pins", 32'h0, 32'(uo_out));
        check_value("reset ready", 32'h0, 32'(data_ready));
        expect_read("reset gpio out", 11'h040, 32'h0);
        for (int k = 0; k < 8; k++) begin
            expect_read("reset select", sel_addr(k), 32'h1);
        end
        for (int s = 0; s < `PERIPH_NUM_SIMPLE; s++) begin
            for (int r = 0; r < 4; r++) begin
                expect_read("reset byte reg", simple_addr(s, r), 32'h0);
            end
        end
        end_test("reset values");
    endtask

    task automatic test_gpio_out();
        logic [31:0] w;
        repeat (3) begin
            w = next_rand();
            bus_write(11'h040, w);
            gpio_out_m = w[7:0];
            expect_read("gpio out readback", 11'h040, 32'(w[7:0]));
            check_value("gpio out pins", 32'(w[7:0]), 32'(uo_out));
        end
        end_test("gpio output");
    endtask

    task automatic test_gpio_in();
        logic [10:0] unmapped [6] = '{11'h000, 11'h048, 11'h05c, 11'h0c4, 11'h3fc, 11'h1c0};
        repeat (4) begin
            ui_in = 8'(next_rand());
            expect_read("gpio in readback", 11'h044, 32'(ui_in));
        end
        // Slot 3 holds nothing, so GPIO must keep its value
        bus_write(11'h0c0, next_rand());
        expect_read("unmapped write ignored", 11'h040, 32'(gpio_out_m));
        foreach (unmapped[i]) begin
            expect_read("unmapped user read", unmapped[i], 32'h0);
        end
        end_test("gpio input and unmapped");
    endtask

    task automatic test_pin_routing();
        logic [31:0] w;
        int          slot;
        for (int s = 0; s < `PERIPH_NUM_SIMPLE; s++) begin
            w = next_rand();
            bus_write(simple_addr(s, 0), w);
            regs_m[s][0] = w[7:0];
        end
        for (int k = 0; k < 8; k++) begin
            // Slots 4 and 5 do not exist
            slot = next_rand() % 6;
            sel_m[k] = 5'h10 | 5'(slot);
            bus_write(sel_addr(k), 32'(sel_m[k]));
            check_value("pin routing", 32'(expected_pins()), 32'(uo_out));
        end
        sel_m[7] = 5'h15;
        bus_write(sel_addr(7), 32'h15);
        check_value("slot 5 pin", 32'h0, 32'(uo_out[7]));
        sel_m[6] = 5'h02;
        bus_write(sel_addr(6), 32'h02);
        check_value("user slot 2 pins", 32'(expected_pins()), 32'(uo_out));
        expect_read("select readback", sel_addr(7), 32'h15);
        end_test("pin routing");
    endtask

    task automatic test_byte_regs();
        logic [31:0] w;
        for (int s = 0; s < `PERIPH_NUM_SIMPLE; s++) begin
            for (int r = 0; r < 4; r++) begin
                w = next_rand();
                bus_write(simple_addr(s, r), w);
                regs_m[s][r] = w[7:0];
            end
        end
        for (int s = 0; s < `PERIPH_NUM_SIMPLE; s++) begin
            for (int r = 0; r < 16; r++) begin
                w = (r < 4) ? 32'(regs_m[s][r]) : 32'h0;
                expect_read("byte reg readback", simple_addr(s, r), w);
            end
        end
        for (int s = `PERIPH_NUM_SIMPLE; s < 16; s++) begin
            expect_read("missing slot read", simple_addr(s, 0), 32'h0);
        end
        check_value("byte reg pins", 32'(expected_pins()), 32'(uo_out));
        end_test("byte registers");
    endtask

    task automatic test_read_hold();
        logic [31:0] d;
        read_held(simple_addr(1, 2), simple_addr(2, 3), 3, d);
        check_value("back-to-back read 1", 32'(regs_m[1][2]), d);
        read_held(simple_addr(2, 3), 11'h040, 2, d);
        check_value("back-to-back read 2", 32'(regs_m[2][3]), d);
        read_held(11'h040, 11'h044, 4, d);
        check_value("back-to-back read 3", 32'(gpio_out_m), d);
        read_held(11'h044, sel_addr(3), 1, d);
        check_value("back-to-back read 4", 32'(ui_in), d);
        expect_read("back-to-back read 5", sel_addr(3), 32'(sel_m[3]));
        expect_read("back-to-back read 6", simple_addr(3, 1), 32'(regs_m[3][1]));
        end_test("read hold");
    endtask

    initial begin
        rst_n = 1'b0;
        ui_in = '0;
        addr = '0;
        data_in = '0;
        data_write_n = ACC_NONE;
        data_read_n = ACC_NONE;
        data_read_complete = 1'b0;
        gpio_out_m = '0;
        foreach (sel_m[k]) sel_m[k] = 5'h01;
        foreach (regs_m[s, r]) regs_m[s][r] = 8'h00;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        test_reset_values();
        test_gpio_out();
        test_gpio_in();
        test_pin_routing();
        test_byte_regs();
        test_read_hold();

        assert_fails = i_periph_hub.i_periph_hub_assertions.fail_count;
        $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 tests_run, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
periph_pkg.sv
addr_decoder.sv
byte_periph.sv
gpio_ctrl.sv
pin_mux.sv
read_return.sv
periph_hub.sv
periph_hub_assertions.sv
tb_periph_hub.sv

//--- Bender.yml
package:
  name: periph_hub

export_include_dirs:
  - .

sources:
  - periph_pkg.sv
  - addr_decoder.sv
  - byte_periph.sv
  - gpio_ctrl.sv
  - pin_mux.sv
  - read_return.sv
  - periph_hub.sv
  - target: test
    files:
      - periph_hub_assertions.sv
      - tb_periph_hub.sv
